// File: logic/cache_geom_pkg.sv
package cache_geom_pkg;

    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;
    localparam int BANKS    = 4;
    localparam int OFFSET_W = 4;
    localparam int LINE_W   = WORD_W * BANKS;
    localparam int STRB_W   = WORD_W / 8;
    localparam int NUM_WAYS = 2;

    // Tag is whatever the index and line offset leave of the address
    function automatic int tag_width(int sets_log2);
        return ADDR_W - sets_log2 - OFFSET_W;
    endfunction

endpackage

// File: logic/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } main_state_t;

    // One word per beat
    localparam int REFILL_BEATS = 4;

endpackage

// File: logic/cache_ifs.sv
`timescale 1ns/100ps

// Request buffer plus the array read strobe
interface req_if #(
    parameter int SETS_LOG2 = 8
) ();
    import cache_geom_pkg::*;
    localparam int TAG_W = tag_width(SETS_LOG2);

    logic                 op;
    logic [SETS_LOG2-1:0] index;
    logic [TAG_W-1:0]     tag;
    logic [OFFSET_W-1:0]  offset;
    logic [STRB_W-1:0]    wstrb;
    logic [WORD_W-1:0]    wdata;
    logic                 victim_way;
    logic                 lookup_en;
    logic [SETS_LOG2-1:0] rd_index;

    modport driver (output op, index, tag, offset, wstrb, wdata, victim_way, lookup_en, rd_index);
    modport reader (input op, index, tag, offset, wstrb, wdata, victim_way, lookup_en, rd_index);
endinterface

interface way_status_if #(
    parameter int SETS_LOG2 = 8
) ();
    import cache_geom_pkg::*;
    localparam int TAG_W = tag_width(SETS_LOG2);

    logic             hit;
    logic             hit_way;
    logic             victim_valid;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;

    modport driver (output hit, hit_way, victim_valid, victim_dirty, victim_tag);
    modport reader (input hit, hit_way, victim_valid, victim_dirty, victim_tag);
endinterface

interface line_fill_if ();
    import cache_geom_pkg::*;

    logic              fill_en;
    logic [LINE_W-1:0] fill_line;
    logic              fill_dirty;

    modport driver (output fill_en, fill_line, fill_dirty);
    modport reader (input fill_en, fill_line, fill_dirty);
endinterface

// File: logic/tag_store.sv
`timescale 1ns/100ps

module tag_store #(
    parameter int SETS_LOG2 = 8,
    localparam int TAG_W = cache_geom_pkg::tag_width(SETS_LOG2)
) (
    input  logic        clk_g,
    input  logic        resetn,
    req_if.reader       req,
    line_fill_if.reader fill,
    way_status_if.driver ws,
    input  logic        state_lookup
);
    import cache_geom_pkg::*;

    localparam int SETS = 1 << SETS_LOG2;

    logic [SETS-1:0]     valid_bits [NUM_WAYS];
    logic [SETS-1:0]     dirty_bits [NUM_WAYS];
    logic [TAG_W-1:0]    tag_mem [NUM_WAYS][SETS];
    logic [TAG_W-1:0]    tag_q [NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q;
    logic [NUM_WAYS-1:0] way_hit;

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_bits[w] <= '0;
                dirty_bits[w] <= '0;
            end
        end else if (fill.fill_en) begin
            valid_bits[req.victim_way][req.index] <= 1'b1;
            dirty_bits[req.victim_way][req.index] <= fill.fill_dirty;
        end else if (state_lookup && |way_hit && req.op) begin
            dirty_bits[way_hit[1]][req.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_g) begin
        if (req.lookup_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                tag_q[w]   <= tag_mem[w][req.rd_index];
                valid_q[w] <= valid_bits[w][req.rd_index];
            end
        end
        if (fill.fill_en) begin
            tag_mem[req.victim_way][req.index] <= req.tag;
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[w] && (tag_q[w] == req.tag);
        end
    end

    assign ws.hit     = |way_hit;
    assign ws.hit_way = way_hit[1];

    // Dirty bits can change after the read, so look them up live
    assign ws.victim_valid = valid_q[req.victim_way];
    assign ws.victim_dirty = dirty_bits[req.victim_way][req.index];
    assign ws.victim_tag   = tag_q[req.victim_way];

endmodule

// File: logic/data_store.sv
`timescale 1ns/100ps

module data_store #(
    parameter int SETS_LOG2 = 8
) (
    input  logic                              clk_g,
    req_if.reader                             req,
    line_fill_if.reader                       fill,
    input  logic                              hit,
    input  logic                              hit_way,
    input  logic                              state_lookup,
    output logic [cache_geom_pkg::LINE_W-1:0] hit_line,
    output logic [cache_geom_pkg::WORD_W-1:0] hit_word
);
    import cache_geom_pkg::*;

    localparam int SETS   = 1 << SETS_LOG2;
    localparam int BANK_W = $clog2(BANKS);

    logic [WORD_W-1:0] mem [NUM_WAYS][BANKS][SETS];
    logic [WORD_W-1:0] bank_q [NUM_WAYS][BANKS];
    logic [BANK_W-1:0] word_sel;
    logic              sel_way;
    logic              store_hit;

    assign word_sel  = req.offset[OFFSET_W-1 -: BANK_W];
    assign store_hit = state_lookup && hit && req.op;

    always_ff @(posedge clk_g) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int b = 0; b < BANKS; b++) begin
                if (req.lookup_en) begin
                    bank_q[w][b] <= mem[w][b][req.rd_index];
                end
                if (fill.fill_en && req.victim_way == 1'(w)) begin
                    mem[w][b][req.index] <= fill.fill_line[b*WORD_W +: WORD_W];
                end else if (store_hit && hit_way == 1'(w) && word_sel == BANK_W'(b)) begin
                    for (int k = 0; k < STRB_W; k++) begin
                        if (req.wstrb[k]) begin
                            mem[w][b][req.index][k*8 +: 8] <= req.wdata[k*8 +: 8];
                        end
                    end
                end
            end
        end
    end

    // On a miss this is the victim line
    assign sel_way = hit ? hit_way : req.victim_way;

    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            hit_line[b*WORD_W +: WORD_W] = bank_q[sel_way][b];
        end
    end

    assign hit_word = bank_q[sel_way][word_sel];

endmodule

// File: logic/miss_handler.sv
`timescale 1ns/100ps

module miss_handler #(
    parameter int SETS_LOG2 = 8,
    localparam int TAG_W = cache_geom_pkg::tag_width(SETS_LOG2)
) (
    input  logic                              clk_g,
    input  logic                              resetn,
    req_if.reader                             req,
    way_status_if.reader                      ws,
    line_fill_if.driver                       fill,
    input  logic [cache_geom_pkg::LINE_W-1:0] victim_line,
    input  logic                              state_lookup,
    input  logic                              state_miss,
    input  logic                              rd_req,
    input  logic                              wr_rdy,
    input  logic                              ret_valid,
    input  logic [cache_geom_pkg::WORD_W-1:0] ret_data,
    output logic                              wr_req,
    output logic [cache_geom_pkg::ADDR_W-1:0] wr_addr,
    output logic [cache_geom_pkg::LINE_W-1:0] wr_data,
    output logic [cache_geom_pkg::ADDR_W-1:0] rd_addr,
    output logic [cache_geom_pkg::WORD_W-1:0] refill_word,
    output logic                              refill_done
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int BEAT_W = $clog2(REFILL_BEATS);

    logic              vic_valid;
    logic              vic_dirty;
    logic [TAG_W-1:0]  vic_tag;
    logic [LINE_W-1:0] vic_line;
    logic [LINE_W-1:0] line_q;
    logic [LINE_W-1:0] merged;
    logic [BEAT_W-1:0] beat;
    logic [BEAT_W-1:0] word_sel;
    logic              done_q;
    logic              wr_req_q;

    assign word_sel = req.offset[OFFSET_W-1 -: BEAT_W];

    always_ff @(posedge clk_g) begin
        if (state_lookup && !ws.hit) begin
            vic_valid <= ws.victim_valid;
            vic_dirty <= ws.victim_dirty;
            vic_tag   <= ws.victim_tag;
            vic_line  <= victim_line;
        end
    end

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            wr_req_q <= 1'b0;
            beat     <= '0;
            done_q   <= 1'b0;
        end else begin
            // Single-cycle burst request once memory is ready
            wr_req_q <= state_miss && wr_rdy && vic_valid && vic_dirty;
            done_q   <= rd_req && ret_valid && (beat == BEAT_W'(REFILL_BEATS - 1));
            if (!rd_req) begin
                beat <= '0;
            end else if (ret_valid) begin
                beat <= beat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_g) begin
        if (rd_req && ret_valid) begin
            line_q[beat*WORD_W +: WORD_W] <= ret_data;
        end
    end

    // Pending store bytes override the refilled word
    always_comb begin
        merged = line_q;
        if (req.op) begin
            for (int k = 0; k < STRB_W; k++) begin
                if (req.wstrb[k]) begin
                    merged[word_sel*WORD_W + k*8 +: 8] = req.wdata[k*8 +: 8];
                end
            end
        end
    end

    assign wr_req  = wr_req_q;
    assign wr_addr = {vic_tag, req.index, {OFFSET_W{1'b0}}};
    assign wr_data = vic_line;
    assign rd_addr = {req.tag, req.index, beat, {(OFFSET_W - BEAT_W){1'b0}}};

    assign refill_word = line_q[word_sel*WORD_W +: WORD_W];
    assign refill_done = done_q;

    assign fill.fill_en    = done_q;
    assign fill.fill_line  = merged;
    assign fill.fill_dirty = req.op;

endmodule

// File: logic/cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl #(
    parameter int SETS_LOG2 = 8,
    localparam int TAG_W = cache_geom_pkg::tag_width(SETS_LOG2)
) (
    input  logic                                clk_g,
    input  logic                                resetn,
    input  logic                                valid,
    input  logic                                op,
    input  logic [SETS_LOG2-1:0]                index,
    input  logic [TAG_W-1:0]                    tag,
    input  logic [cache_geom_pkg::OFFSET_W-1:0] offset,
    input  logic [cache_geom_pkg::STRB_W-1:0]   wstrb,
    input  logic [cache_geom_pkg::WORD_W-1:0]   wdata,
    input  logic                                wr_rdy,
    input  logic                                rd_rdy,
    input  logic                                refill_done,
    output logic                                addr_ok,
    output logic                                data_ok,
    output logic                                rd_req,
    output logic                                state_lookup,
    output logic                                state_miss,
    req_if.driver                               req,
    way_status_if.reader                        ws
);
    import cache_ctrl_pkg::*;

    main_state_t state;
    main_state_t next_state;
    logic [7:0]  lfsr;
    logic        feedback;

    assign addr_ok      = (state == IDLE) && valid;
    assign data_ok      = ((state == LOOKUP) && ws.hit) || refill_done;
    assign rd_req       = (state == REFILL) && !refill_done;
    assign state_lookup = (state == LOOKUP);
    assign state_miss   = (state == MISS);

    // Arrays are read with the incoming index in the accept cycle
    assign req.lookup_en = addr_ok;
    assign req.rd_index  = index;

    always_ff @(posedge clk_g) begin
        if (addr_ok) begin
            req.op     <= op;
            req.index  <= index;
            req.tag    <= tag;
            req.offset <= offset;
            req.wstrb  <= wstrb;
            req.wdata  <= wdata;
        end
    end

    // Zero state is legal, the all-low-bits term keeps it moving
    assign feedback = lfsr[7] ^ ~|lfsr[6:0];

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            lfsr           <= '0;
            req.victim_way <= 1'b0;
        end else begin
            lfsr <= {lfsr[6:4], lfsr[3:1] ^ {3{feedback}}, lfsr[0], feedback};
            if (state == IDLE) begin
                req.victim_way <= lfsr[0];
            end
        end
    end

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (valid) next_state = LOOKUP;
            LOOKUP:  next_state = ws.hit ? IDLE : MISS;
            // Clean or empty victims skip the write-back
            MISS:    if (wr_rdy || !ws.victim_dirty || !ws.victim_valid) next_state = REPLACE;
            REPLACE: if (rd_rdy) next_state = REFILL;
            REFILL:  if (refill_done) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

endmodule

// File: logic/cache_top.sv
`timescale 1ns/100ps

module cache_top #(
    parameter int SETS_LOG2 = 8,
    localparam int TAG_W = cache_geom_pkg::tag_width(SETS_LOG2)
) (
    input  logic                                  clk_g,
    input  logic                                  resetn,
    input  logic                                  valid,
    input  logic                                  op,
    input  logic [SETS_LOG2-1:0]                  index,
    input  logic [TAG_W-1:0]                      tag,
    input  logic [cache_geom_pkg::OFFSET_W-1:0]   offset,
    input  logic [cache_geom_pkg::STRB_W-1:0]     wstrb,
    input  logic [cache_geom_pkg::WORD_W-1:0]     wdata,
    output logic                                  addr_ok,
    output logic                                  data_ok,
    output logic [cache_geom_pkg::WORD_W-1:0]     rdata,
    output logic                                  rd_req,
    output logic [cache_geom_pkg::ADDR_W-1:0]     rd_addr,
    input  logic                                  rd_rdy,
    input  logic                                  ret_valid,
    input  logic [cache_geom_pkg::WORD_W-1:0]     ret_data,
    output logic                                  wr_req,
    output logic [cache_geom_pkg::ADDR_W-1:0]     wr_addr,
    output logic [cache_geom_pkg::LINE_W-1:0]     wr_data,
    input  logic                                  wr_rdy
);
    logic                                state_lookup;
    logic                                state_miss;
    logic                                refill_done;
    logic [cache_geom_pkg::LINE_W-1:0]   hit_line;
    logic [cache_geom_pkg::WORD_W-1:0]   hit_word;
    logic [cache_geom_pkg::WORD_W-1:0]   refill_word;

    req_if #(.SETS_LOG2(SETS_LOG2)) req ();
    way_status_if #(.SETS_LOG2(SETS_LOG2)) ws ();
    line_fill_if fill ();

    // Hit data in LOOKUP, unmerged refill word otherwise
    assign rdata = state_lookup ? hit_word : refill_word;

    cache_ctrl #(.SETS_LOG2(SETS_LOG2)) u_cache_ctrl (
        .clk_g        (clk_g),
        .resetn       (resetn),
        .valid        (valid),
        .op           (op),
        .index        (index),
        .tag          (tag),
        .offset       (offset),
        .wstrb        (wstrb),
        .wdata        (wdata),
        .wr_rdy       (wr_rdy),
        .rd_rdy       (rd_rdy),
        .refill_done  (refill_done),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rd_req       (rd_req),
        .state_lookup (state_lookup),
        .state_miss   (state_miss),
        .req          (req.driver),
        .ws           (ws.reader)
    );

    tag_store #(.SETS_LOG2(SETS_LOG2)) u_tag_store (
        .clk_g        (clk_g),
        .resetn       (resetn),
        .req          (req.reader),
        .fill         (fill.reader),
        .ws           (ws.driver),
        .state_lookup (state_lookup)
    );

    data_store #(.SETS_LOG2(SETS_LOG2)) u_data_store (
        .clk_g        (clk_g),
        .req          (req.reader),
        .fill         (fill.reader),
        .hit          (ws.hit),
        .hit_way      (ws.hit_way),
        .state_lookup (state_lookup),
        .hit_line     (hit_line),
        .hit_word     (hit_word)
    );

    miss_handler #(.SETS_LOG2(SETS_LOG2)) u_miss_handler (
        .clk_g        (clk_g),
        .resetn       (resetn),
        .req          (req.reader),
        .ws           (ws.reader),
        .fill         (fill.driver),
        .victim_line  (hit_line),
        .state_lookup (state_lookup),
        .state_miss   (state_miss),
        .rd_req       (rd_req),
        .wr_rdy       (wr_rdy),
        .ret_valid    (ret_valid),
        .ret_data     (ret_data),
        .wr_req       (wr_req),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_addr      (rd_addr),
        .refill_word  (refill_word),
        .refill_done  (refill_done)
    );

endmodule

// File: verification/mem_model.sv
`timescale 1ns/100ps

module mem_model (
    input  logic                              clk_g,
    input  logic                              valid,
    input  logic                              addr_ok,
    input  logic                              op,
    input  logic [cache_geom_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [cache_geom_pkg::STRB_W-1:0] wstrb,
    input  logic [cache_geom_pkg::WORD_W-1:0] wdata,
    input  logic                              rd_req,
    input  logic [cache_geom_pkg::ADDR_W-1:0] rd_addr,
    output logic                              rd_rdy,
    output logic                              ret_valid,
    output logic [cache_geom_pkg::WORD_W-1:0] ret_data,
    input  logic                              wr_req,
    input  logic [cache_geom_pkg::ADDR_W-1:0] wr_addr,
    input  logic [cache_geom_pkg::LINE_W-1:0] wr_data,
    output logic                              wr_rdy,
    output logic [cache_geom_pkg::WORD_W-1:0] exp_rdata,
    output logic [cache_geom_pkg::LINE_W-1:0] exp_line,
    output logic                              exp_dirty
);
    import cache_geom_pkg::*;

    // 16 lines of 4 words at the bottom of the address space
    localparam int WORDS = 64;

    logic [WORD_W-1:0] mem [WORDS];
    logic [7:0]        shadow [WORDS*4];
    logic [15:0]       line_dirty;

    function automatic logic [WORD_W-1:0] fill_word(input int a);
        return 32'h3c6e_f372 ^ (a * 32'h9e37_79b9);
    endfunction

    // Shadow bytes hold every store the CPU side has issued
    function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        logic [7:0] base;
        base = {addr[7:2], 2'b00};
        return {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
    endfunction

    function automatic logic [LINE_W-1:0] expected_line(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] line;
        for (int w = 0; w < BANKS; w++) begin
            line[w*WORD_W +: WORD_W] = expected_word({addr[31:4], 2'(w), 2'b00});
        end
        return line;
    endfunction

    initial begin
        rd_rdy     = 1'b0;
        ret_valid  = 1'b0;
        ret_data   = '0;
        wr_rdy     = 1'b0;
        exp_rdata  <= '0;
        exp_line   <= '0;
        exp_dirty  <= 1'b0;
        line_dirty <= '0;
        for (int a = 0; a < WORDS; a++) begin
            mem[a] <= fill_word(a * 4);
            for (int k = 0; k < STRB_W; k++) begin
                shadow[a*4 + k] <= fill_word(a * 4) >> (k * 8);
            end
        end
    end

    // Random ready and beat gaps
    always @(posedge clk_g) begin
        #1;
        wr_rdy    = ($urandom_range(3) != 0);
        rd_rdy    = ($urandom_range(3) != 0);
        ret_valid = rd_req && ($urandom_range(3) != 0);
        ret_data  = mem[rd_addr[7:2]];
    end

    always @(negedge clk_g) begin
        // wr_addr settles in MISS, a cycle before wr_req
        exp_line  <= expected_line(wr_addr);
        exp_dirty <= line_dirty[wr_addr[7:4]];
        if (wr_req) begin
            for (int w = 0; w < BANKS; w++) begin
                mem[{wr_addr[7:4], 2'(w)}] <= wr_data[w*WORD_W +: WORD_W];
            end
            line_dirty[wr_addr[7:4]] <= 1'b0;
        end
        if (valid && addr_ok && op) begin
            for (int k = 0; k < STRB_W; k++) begin
                if (wstrb[k]) begin
                    shadow[{cpu_addr[7:2], 2'(k)}] <= wdata[k*8 +: 8];
                end
            end
            line_dirty[cpu_addr[7:4]] <= 1'b1;
        end
        if (valid && addr_ok && !op) begin
            exp_rdata <= expected_word(cpu_addr);
        end
    end

endmodule

// File: verification/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;
    import cache_geom_pkg::*;

    localparam int SETS_LOG2   = 2;
    localparam int TAG_W       = tag_width(SETS_LOG2);
    localparam int NUM_OPS     = 325;
    localparam int CYCLE_LIMIT = 400 * NUM_OPS;

    logic                 clk_g = 1'b0;
    logic                 resetn;
    logic                 valid;
    logic                 op;
    logic [SETS_LOG2-1:0] index;
    logic [TAG_W-1:0]     tag;
    logic [OFFSET_W-1:0]  offset;
    logic [STRB_W-1:0]    wstrb;
    logic [WORD_W-1:0]    wdata;
    logic                 addr_ok;
    logic                 data_ok;
    logic [WORD_W-1:0]    rdata;
    logic                 rd_req;
    logic [ADDR_W-1:0]    rd_addr;
    logic                 rd_rdy;
    logic                 ret_valid;
    logic [WORD_W-1:0]    ret_data;
    logic                 wr_req;
    logic [ADDR_W-1:0]    wr_addr;
    logic [LINE_W-1:0]    wr_data;
    logic                 wr_rdy;
    logic [ADDR_W-1:0]    cpu_addr;
    logic [WORD_W-1:0]    exp_rdata;
    logic [LINE_W-1:0]    exp_line;
    logic                 exp_dirty;

    string test_name;
    int    cycles = 0;
    int    errors = 0;
    int    wb_count = 0;
    int    beats_seen = 0;
    logic  load_pending = 1'b0;
    int    lat;
    logic  missed;

    always #4 clk_g = ~clk_g;

    assign cpu_addr = {tag, index, offset};

    cache_top #(.SETS_LOG2(SETS_LOG2)) u_cache_top (
        .clk_g     (clk_g),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    mem_model u_mem_model (
        .clk_g     (clk_g),
        .valid     (valid),
        .addr_ok   (addr_ok),
        .op        (op),
        .cpu_addr  (cpu_addr),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .exp_rdata (exp_rdata),
        .exp_line  (exp_line),
        .exp_dirty (exp_dirty)
    );

    task automatic check(input string name, input logic [LINE_W-1:0] expected,
                         input logic [LINE_W-1:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Check %s failed", name);
        end
    endtask

    // One request through the CPU handshake up to its data_ok
    task automatic issue(input logic is_store, input logic [ADDR_W-1:0] addr,
                         input logic [STRB_W-1:0] strb, input logic [WORD_W-1:0] data,
                         output int latency, output logic saw_rd);
        @(posedge clk_g);
        #1;
        valid = 1'b1;
        op = is_store;
        {tag, index, offset} = addr;
        wstrb = strb;
        wdata = data;
        @(negedge clk_g);
        check({test_name, " addr_ok"}, 1, addr_ok);
        @(posedge clk_g);
        #1;
        valid = 1'b0;
        latency = 0;
        saw_rd = 1'b0;
        do begin
            @(negedge clk_g);
            latency++;
            if (rd_req) begin
                saw_rd = 1'b1;
            end
        end while (!data_ok);
    endtask

    always @(negedge clk_g) begin
        if (resetn) begin
            if (valid && addr_ok) begin
                load_pending = !op;
            end
            if (data_ok && load_pending) begin
                check({test_name, " rdata"}, exp_rdata, rdata);
            end
            // Requested line, word field advances only on taken beats
            if (rd_req) begin
                check({test_name, " rd_addr"},
                      {cpu_addr[ADDR_W-1:OFFSET_W], 2'(beats_seen), 2'b00}, rd_addr);
                if (ret_valid) begin
                    beats_seen++;
                end
            end else begin
                beats_seen = 0;
            end
            if (wr_req) begin
                wb_count++;
                check({test_name, " wr_data"}, exp_line, wr_data);
                check({test_name, " victim dirty"}, 1, exp_dirty);
            end
        end
    end

    always @(posedge clk_g) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        logic [ADDR_W-1:0] addr;
        void'($urandom(32'h5e98_9f82));
        resetn = 1'b0;
        valid = 1'b0;
        op = 1'b0;
        index = '0;
        tag = '0;
        offset = '0;
        wstrb = '0;
        wdata = '0;
        test_name = "reset";
        repeat (2) @(posedge clk_g);
        #1;
        resetn = 1'b1;
        repeat (4) begin
            @(negedge clk_g);
            check("reset data_ok", 0, data_ok);
            check("reset rd_req", 0, rd_req);
            check("reset wr_req", 0, wr_req);
            check("reset addr_ok", 0, addr_ok);
        end

        test_name = "read_miss_hit";
        issue(1'b0, 32'h40, 4'h0, 32'h0, lat, missed);
        check("read_miss_hit refill", 1, missed);
        issue(1'b0, 32'h40, 4'h0, 32'h0, lat, missed);
        check("read_miss_hit latency", 1, lat);
        check("read_miss_hit rd_req", 0, missed);

        test_name = "store_hit";
        issue(1'b1, 32'h44, 4'b0101, 32'hdead_beef, lat, missed);
        check("store_hit latency", 1, lat);
        issue(1'b0, 32'h44, 4'h0, 32'h0, lat, missed);

        test_name = "store_miss_merge";
        issue(1'b1, 32'h98, 4'b1100, 32'h1234_5678, lat, missed);
        check("store_miss_merge refill", 1, missed);
        for (int w = 0; w < BANKS; w++) begin
            issue(1'b0, 32'h90 + 32'(w * 4), 4'h0, 32'h0, lat, missed);
        end

        // Set 0 all dirty, set 1 mostly clean
        test_name = "dirty_writeback";
        repeat (2) begin
            for (int i = 0; i < 4; i++) begin
                issue(1'b1, 32'(i << 6), 4'hf, $urandom, lat, missed);
            end
        end
        repeat (2) begin
            for (int i = 0; i < 4; i++) begin
                issue(1'b0, 32'((i << 6) | 'h10), 4'h0, 32'h0, lat, missed);
            end
        end
        check("dirty_writeback count", 1, wb_count > 0);

        test_name = "random_mix";
        for (int n = 0; n < 300; n++) begin
            addr = {24'h0, 4'($urandom_range(15)), 2'($urandom_range(3)), 2'b00};
            if ($urandom_range(1) == 1) begin
                issue(1'b1, addr, 4'($urandom_range(15, 1)), $urandom, lat, missed);
            end else begin
                issue(1'b0, addr, 4'h0, 32'h0, lat, missed);
            end
        end

        @(negedge clk_g);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/cache_ifs.sv
logic/tag_store.sv
logic/data_store.sv
logic/miss_handler.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verification/mem_model.sv
verification/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module cache_tb -o cache_tb_sim \
    && { ./obj_dir/cache_tb_sim > sim.log 2>&1; cat sim.log; } \
    || { echo "Verilator build failed"; exit 1; }
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation finished without failures"; exit 0; }
